// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f mem_manager.f --top-module mem_manager_tb -Mdir obj_dir

run: build
	./obj_dir/Vmem_manager_tb | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing -f mem_manager.f --top-module mem_manager_tb

clean:
	rm -rf obj_dir sim.log

// ==== mem_manager.f ====
+incdir+.
src/mem_manager_pkg.sv
src/access_tracker.sv
src/scratch_ram.sv
src/ext_mem_port.sv
src/access_sequencer.sv
src/mem_manager.sv
sim/ext_mem_responder.sv
sim/mem_manager_tb.sv

// ==== mem_manager_defs.svh ====
`ifndef MEM_MANAGER_DEFS_SVH
`define MEM_MANAGER_DEFS_SVH

// --------------------------------------------------
// system bus widths
// --------------------------------------------------
`define ADDR_W 18                  // word address
`define DATA_W 32                  // data word

// --------------------------------------------------
// slot timing inside one system cycle
// --------------------------------------------------
`define SLOTS_PER_CYCLE 10         // fast clocks per system clock
`define LATCH_SLOT 1               // bus sampled here, first publish slot
`define NO_RETURN 2                // closing slots, nothing published
`define SLOT_W 4                   // slot counter width

// --------------------------------------------------
// scratch window, mapped onto the on-chip RAM
// --------------------------------------------------
`define SCRATCH_BASE 230403
`define SCRATCH_WORDS 16384
`define SCRATCH_AW 14              // log2 of the window size

`endif

// ==== sim/ext_mem_responder.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// external memory model, answers the four-phase req/ack with random delays
module ext_mem_responder (
	input  logic modified_clock_sram,
	input  logic rst,
	input  logic ext_req,
	input  mem_manager_pkg::mem_word_req_t ext_cmd,
	output logic ext_ack,
	output logic [`DATA_W-1:0] ext_rdata
);

	// sparse storage, unwritten words read as 0
	logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];
	int unsigned delay;

	initial begin
		ext_ack   = 1'b0;
		ext_rdata = '0;
		forever begin
			// wait for a request, looked at just after the edge
			do begin
				@(posedge modified_clock_sram);
				#1;
			end while (!ext_req || rst);

			delay = $urandom_range(25); // ack latency in clocks
			repeat (delay) @(posedge modified_clock_sram);
			if (delay > 0) begin
				#1;
			end

			if (ext_cmd.wren) begin
				mem[ext_cmd.addr] = ext_cmd.wdata;
			end else if (mem.exists(ext_cmd.addr)) begin
				ext_rdata = mem[ext_cmd.addr];
			end else begin
				ext_rdata = '0;
			end
			ext_ack = 1'b1; // data valid with ack

			// release only after req has dropped
			do begin
				@(posedge modified_clock_sram);
				#1;
			end while (ext_req);
			ext_ack = 1'b0;
		end
	end

endmodule

// ==== sim/mem_manager_tb.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

module mem_manager_tb;

	localparam int N_TXN = 40;                     // transactions per random test
	localparam int TOTAL_TXN = 4 * N_TXN + 8;      // with margin for the cache test
	localparam int SEED = 90934;

	logic modified_clock_sram;
	logic rst;
	logic [`SLOT_W-1:0] slot;
	logic ext_ready;
	mem_manager_pkg::mem_word_req_t sys_req;
	logic pause;
	logic [`DATA_W-1:0] data_read;
	logic ext_req;
	mem_manager_pkg::mem_word_req_t ext_cmd;
	logic ext_ack;
	logic [`DATA_W-1:0] ext_rdata;

	// reference model and bookkeeping
	logic [`DATA_W-1:0] model [logic [`ADDR_W-1:0]];
	mem_manager_pkg::mem_word_req_t prev_req;
	logic prev_valid;
	logic [`ADDR_W-1:0] scr_pool [6];
	logic [`ADDR_W-1:0] ext_pool [6];
	logic [`DATA_W-1:0] data_pool [4];
	int errors;
	int checks;
	int tests;

	// per-transaction observations
	logic saw_pause;
	int req_count;
	mem_manager_pkg::mem_word_req_t cmd_seen;
	logic last_ext_req_q = 1'b0;

	// slot legality tracking
	logic [`SLOT_W-1:0] last_slot;
	logic last_pause;
	logic [`DATA_W-1:0] last_dr;
	logic slot_wrap;

	mem_manager dut0 (
		.modified_clock_sram (modified_clock_sram),
		.rst                 (rst),
		.slot                (slot),
		.ext_ready           (ext_ready),
		.sys_req             (sys_req),
		.pause               (pause),
		.data_read           (data_read),
		.ext_req             (ext_req),
		.ext_cmd             (ext_cmd),
		.ext_ack             (ext_ack),
		.ext_rdata           (ext_rdata)
	);

	ext_mem_responder u_responder (
		.modified_clock_sram (modified_clock_sram),
		.rst                 (rst),
		.ext_req             (ext_req),
		.ext_cmd             (ext_cmd),
		.ext_ack             (ext_ack),
		.ext_rdata           (ext_rdata)
	);

	initial begin
		modified_clock_sram = 1'b0;
		forever #10 modified_clock_sram = ~modified_clock_sram;
	end

	// slot counter, moves with the other stimulus
	always @(posedge modified_clock_sram) begin
		slot_wrap = rst || slot == `SLOT_W'(`SLOTS_PER_CYCLE - 1); // decided at the edge
		#1;
		if (slot_wrap) begin
			slot = '0;
		end else begin
			slot = slot + 1'b1;
		end
	end

	// --------------------------------------------------
	// monitors, sampled on the falling edge
	// --------------------------------------------------
	always @(negedge modified_clock_sram) begin
		if (pause) saw_pause = 1'b1;
		if (ext_req && req_count == 0) cmd_seen = ext_cmd; // first req of this access
		if (ext_req && !last_ext_req_q) req_count++;
		last_ext_req_q = ext_req;
		// last_slot is what the edge just passed saw
		if (!rst && (pause !== last_pause || data_read !== last_dr)) begin
			check(`DATA_W'(last_slot >= `SLOT_W'(`LATCH_SLOT) &&
				last_slot <= `SLOT_W'(`SLOTS_PER_CYCLE - 1 - `NO_RETURN)),
				`DATA_W'(1), "pause or data_read moved outside slots 1..7");
		end
		last_slot  = slot;
		last_pause = pause;
		last_dr    = data_read;
	end

	task automatic check(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
		input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	// one system access, driven at slot 0 and checked when it has finished
	task automatic run_txn(input mem_manager_pkg::mem_word_req_t req);
		logic exp_hit;
		logic is_scr;
		logic [`DATA_W-1:0] exp_data;
		// bus only moves once nothing is in flight
		do @(negedge modified_clock_sram);
		while (slot != `SLOT_W'(`SLOTS_PER_CYCLE - 1) || pause);
		@(posedge modified_clock_sram);
		#1;
		sys_req   = req;
		saw_pause = 1'b0;
		req_count = 0;
		exp_hit = prev_valid && prev_req.addr == req.addr &&
			(!req.wren || (prev_req.wren && prev_req.wdata == req.wdata));
		is_scr = req.addr >= `ADDR_W'(`SCRATCH_BASE) &&
			req.addr < `ADDR_W'(`SCRATCH_BASE + `SCRATCH_WORDS);
		if (req.wren) exp_data = req.wdata;     // pass-through
		else if (model.exists(req.addr)) exp_data = model[req.addr];
		else exp_data = '0;
		do @(negedge modified_clock_sram); while (slot != `SLOT_W'(2)); // sampled
		do @(negedge modified_clock_sram); while (!(slot == '0 && !pause));
		check(data_read, exp_data, "data_read");
		if (exp_hit) begin
			check(`DATA_W'(saw_pause), '0, "pause on a cache hit");
			check(`DATA_W'(req_count), '0, "ext_req on a cache hit");
		end else begin
			check(`DATA_W'(saw_pause), `DATA_W'(1), "no pause on a miss");
			if (is_scr) begin
				check(`DATA_W'(req_count), '0, "ext_req on a scratch access");
			end else begin
				check(`DATA_W'(req_count), `DATA_W'(1), "ext_req count on external access");
				check(`DATA_W'(cmd_seen.addr), `DATA_W'(req.addr), "ext_cmd addr");
				check(`DATA_W'(cmd_seen.wren), `DATA_W'(req.wren), "ext_cmd wren");
				if (req.wren) check(cmd_seen.wdata, req.wdata, "ext_cmd wdata");
			end
		end
		if (req.wren) model[req.addr] = req.wdata;
		prev_req   = req;
		prev_valid = 1'b1;
	endtask

	function automatic mem_manager_pkg::mem_word_req_t rand_req(input int pool_sel);
		mem_manager_pkg::mem_word_req_t r;
		r.wren  = 1'($urandom_range(1));
		r.addr  = (pool_sel == 0) ? scr_pool[$urandom_range(5)] : ext_pool[$urandom_range(5)];
		r.wdata = data_pool[$urandom_range(3)];
		return r;
	endfunction

	task automatic report(input string name, input int err_before);
		tests++;
		$display("test %-8s %s (%0d errors)", name,
			(errors == err_before) ? "ok" : "failed", errors - err_before);
	endtask

	task automatic random_test(input string name, input int mode);
		int e0;
		e0 = errors;
		for (int i = 0; i < N_TXN; i++) begin
			run_txn(rand_req((mode == 2) ? int'($urandom_range(1)) : mode));
		end
		report(name, e0);
	endtask

	// held requests and repeated writes must not touch memory
	task automatic cache_test();
		int e0;
		mem_manager_pkg::mem_word_req_t r;
		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			r = rand_req(i % 2);
			run_txn(r);
			run_txn(r);  // held, hit
			r.wren = 1'b0;
			run_txn(r);  // read back the same word
		end
		report("cache", e0);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int e0;
		void'($urandom(SEED));
		rst = 1'b1;
		slot = '0;
		ext_ready = 1'b0;
		sys_req = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		prev_valid = 1'b0;
		for (int i = 0; i < 6; i++) scr_pool[i] = `ADDR_W'(`SCRATCH_BASE + i * 3);
		scr_pool[5] = `ADDR_W'(`SCRATCH_BASE + `SCRATCH_WORDS - 1); // top of window
		ext_pool = '{`ADDR_W'(0), `ADDR_W'(5), `ADDR_W'(1000), `ADDR_W'(`SCRATCH_BASE - 1),
			`ADDR_W'(`SCRATCH_BASE + `SCRATCH_WORDS), `ADDR_W'(262143)};
		for (int i = 0; i < 4; i++) data_pool[i] = $urandom;
		repeat (4) @(posedge modified_clock_sram);
		#1 rst = 1'b0;

		// quiet outputs until the first request
		e0 = errors;
		repeat (3 * `SLOTS_PER_CYCLE) begin
			@(negedge modified_clock_sram);
			check(`DATA_W'(pause), '0, "pause after reset");
			check(`DATA_W'(ext_req), '0, "ext_req after reset");
			check(data_read, '0, "data_read after reset");
		end
		report("reset", e0);
		@(posedge modified_clock_sram);
		#1;
		ext_ready = 1'b1;
		// idle bus gets sampled as soon as the FSM leaves start
		prev_req   = sys_req;
		prev_valid = 1'b1;

		random_test("scratch", 0);
		random_test("external", 1);
		cache_test();
		random_test("mixed", 2);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TOTAL_TXN * 40 * 200);
		$display("timeout: the run did not finish in the allowed time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src/access_sequencer.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// main FSM: dispatch, wait, slot-legal publish of pause and data_read
module access_sequencer (
	input  logic modified_clock_sram,
	input  logic rst,
	input  logic [`SLOT_W-1:0] slot,
	input  logic ext_ready,
	input  mem_manager_pkg::mem_word_req_t sys_req,
	input  mem_manager_pkg::access_t access,
	output logic sample,
	output logic scratch_we,
	output logic [`SCRATCH_AW-1:0] scratch_addr,
	output logic [`DATA_W-1:0] scratch_wdata,
	input  logic [`DATA_W-1:0] scratch_rdata,
	output logic ext_start,
	input  logic ext_done,
	input  logic [`DATA_W-1:0] ext_rdata,
	output logic pause,
	output logic [`DATA_W-1:0] data_read
);

	// legal publishing window, slots 1 to 7
	localparam logic [`SLOT_W-1:0] FIRST_SLOT = `SLOT_W'(`LATCH_SLOT);
	localparam logic [`SLOT_W-1:0] LAST_SLOT =
		`SLOT_W'(`SLOTS_PER_CYCLE - 1 - `NO_RETURN);

	typedef enum logic [3:0] {
		ST_START,        // waiting for external memory ready
		ST_IDLE,
		ST_SCR_WRITE,
		ST_SCR_READ,
		ST_SCR_READ_RDY,
		ST_EXT_WAIT,
		ST_VALID,        // result ready, waiting for a legal slot
		ST_NR_WAIT,      // finished in no-return slots
		ST_NR_RELEASE    // slot 0 passed, publish at next legal slot
	} seq_state_t;

	seq_state_t state;

	logic [`DATA_W-1:0] pending; // result to publish
	logic ext_is_read;           // external access needs its read data
	logic legal_slot;
	logic publish;

	assign legal_slot = (slot >= FIRST_SLOT) && (slot <= LAST_SLOT);
	assign sample     = (state == ST_IDLE) && (slot == FIRST_SLOT);

	// both waiting states release the same way
	assign publish = legal_slot && ((state == ST_VALID) || (state == ST_NR_RELEASE));

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	always_ff @(posedge modified_clock_sram) begin
		if (rst) begin
			state      <= ST_START;
			pause      <= 1'b0;
			data_read  <= '0;
			scratch_we <= 1'b0;
			ext_start  <= 1'b0;
		end else begin
			scratch_we <= 1'b0; // both are one clock pulses
			ext_start  <= 1'b0;
			if (publish) begin
				pause     <= 1'b0;
				data_read <= pending;
			end
			case (state)
				ST_START: begin
					if (ext_ready && slot == '0) begin
						state <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					if (sample) begin
						if (access.hit) begin
							state <= ST_VALID; // cached, republish same value
						end else begin
							pause <= 1'b1; // slot 1, legal
							if (access.region == mem_manager_pkg::REGION_SCRATCH) begin
								if (sys_req.wren) begin
									scratch_we <= 1'b1;
									state      <= ST_SCR_WRITE;
								end else begin
									state <= ST_SCR_READ;
								end
							end else begin
								ext_start <= 1'b1;
								state     <= ST_EXT_WAIT;
							end
						end
					end
				end
				ST_SCR_WRITE:    state <= ST_VALID; // write lands this clock
				ST_SCR_READ:     state <= ST_SCR_READ_RDY;
				ST_SCR_READ_RDY: state <= ST_VALID;
				ST_EXT_WAIT: begin
					if (ext_done) begin
						state <= ST_VALID;
					end
				end
				ST_VALID: begin
					if (publish) begin
						state <= ST_IDLE;
					end else if (slot > LAST_SLOT) begin
						state <= ST_NR_WAIT; // slots 8, 9
					end
					// slot 0 just waits here for slot 1
				end
				ST_NR_WAIT: begin
					if (slot == '0) begin
						state <= ST_NR_RELEASE;
					end
				end
				ST_NR_RELEASE: begin
					if (publish) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_START;
			endcase
		end
	end

	// --------------------------------------------------
	// datapath registers
	// --------------------------------------------------
	always_ff @(posedge modified_clock_sram) begin
		if (sample && !access.hit) begin
			scratch_addr  <= access.offset;
			scratch_wdata <= sys_req.wdata;
			pending       <= sys_req.wdata; // writes pass through to data_read
			ext_is_read   <= !sys_req.wren;
		end
		if (state == ST_SCR_READ_RDY) begin
			pending <= scratch_rdata;
		end
		if (state == ST_EXT_WAIT && ext_done && ext_is_read) begin
			pending <= ext_rdata;
		end
	end

endmodule

// ==== src/access_tracker.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// single-word cache record plus address decode
module access_tracker (
	input  logic modified_clock_sram,
	input  logic rst,
	input  mem_manager_pkg::mem_word_req_t sys_req,
	input  logic sample,
	output mem_manager_pkg::access_t access
);

	// window bounds, sized to the bus
	localparam logic [`ADDR_W-1:0] WIN_BASE = `ADDR_W'(`SCRATCH_BASE);
	localparam logic [`ADDR_W-1:0] WIN_SIZE = `ADDR_W'(`SCRATCH_WORDS);

	mem_manager_pkg::mem_word_req_t rec; // last sampled request
	logic rec_valid;                     // nothing recorded yet after reset

	logic [`ADDR_W-1:0] win_off;         // address relative to window base
	logic in_window;
	logic same_addr;
	logic same_write;

	// --------------------------------------------------
	// record, updated only when the bus is sampled
	// --------------------------------------------------
	always_ff @(posedge modified_clock_sram) begin
		if (rst) begin
			rec_valid <= 1'b0;
		end else if (sample) begin
			rec_valid <= 1'b1;
		end
	end

	always_ff @(posedge modified_clock_sram) begin
		if (sample) begin
			rec <= sys_req; // address, wren and data together
		end
	end

	// --------------------------------------------------
	// hit check
	// --------------------------------------------------
	assign same_addr = rec_valid && (sys_req.addr == rec.addr);

	// a repeated write only counts if the data is unchanged too
	assign same_write = sys_req.wren && rec.wren && (sys_req.wdata == rec.wdata);

	// --------------------------------------------------
	// region decode
	// --------------------------------------------------
	// below the base wraps to a large offset, so one compare covers both ends
	assign win_off   = sys_req.addr - WIN_BASE;
	assign in_window = (win_off < WIN_SIZE);

	always_comb begin
		access.hit    = same_addr && (!sys_req.wren || same_write);
		access.region = in_window ? mem_manager_pkg::REGION_SCRATCH
		                          : mem_manager_pkg::REGION_EXT;
		access.offset = win_off[`SCRATCH_AW-1:0]; // meaningful only in window
	end

endmodule

// ==== src/ext_mem_port.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// four-phase req/ack master toward external memory
module ext_mem_port (
	input  logic modified_clock_sram,
	input  logic rst,
	input  logic start,
	input  mem_manager_pkg::mem_word_req_t cmd,
	output logic done,
	output logic [`DATA_W-1:0] rdata,
	output logic ext_req,
	output mem_manager_pkg::mem_word_req_t ext_cmd,
	input  logic ext_ack,
	input  logic [`DATA_W-1:0] ext_rdata
);

	typedef enum logic [1:0] {
		P_IDLE,      // waiting for start
		P_SETUP,     // command settling before req
		P_WAIT_ACK,  // req high, ack pending
		P_WAIT_REL   // req dropped, ack still high
	} port_state_t;

	port_state_t state;

	// --------------------------------------------------
	// handshake FSM
	// --------------------------------------------------
	always_ff @(posedge modified_clock_sram) begin
		if (rst) begin
			state   <= P_IDLE;
			ext_req <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0; // single clock pulse
			case (state)
				P_IDLE: begin
					if (start) begin
						state <= P_SETUP;
					end
				end
				P_SETUP: begin
					ext_req <= 1'b1; // cmd already stable one clock
					state   <= P_WAIT_ACK;
				end
				P_WAIT_ACK: begin
					if (ext_ack) begin
						ext_req <= 1'b0;
						state   <= P_WAIT_REL;
					end
				end
				P_WAIT_REL: begin
					if (!ext_ack) begin
						done  <= 1'b1; // responder released, port free again
						state <= P_IDLE;
					end
				end
				default: begin
					ext_req <= 1'b0;
					state   <= P_IDLE;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// command and read data holding
	// --------------------------------------------------
	always_ff @(posedge modified_clock_sram) begin
		if (state == P_IDLE && start) begin
			ext_cmd <= cmd; // held for the whole transaction
		end
		if (state == P_WAIT_ACK && ext_ack) begin
			rdata <= ext_rdata; // valid with ack
		end
	end

endmodule

// ==== src/mem_manager.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// memory manager top, slow system bus served from the fast memory clock
module mem_manager (
	input  logic modified_clock_sram,
	input  logic rst,
	input  logic [`SLOT_W-1:0] slot,
	input  logic ext_ready,
	input  mem_manager_pkg::mem_word_req_t sys_req,
	output logic pause,
	output logic [`DATA_W-1:0] data_read,
	output logic ext_req,
	output mem_manager_pkg::mem_word_req_t ext_cmd,
	input  logic ext_ack,
	input  logic [`DATA_W-1:0] ext_rdata
);

	// --------------------------------------------------
	// internal wiring
	// --------------------------------------------------
	mem_manager_pkg::access_t access; // decoded request
	logic sample;
	logic scratch_we;
	logic [`SCRATCH_AW-1:0] scratch_addr;
	logic [`DATA_W-1:0] scratch_wdata;
	logic [`DATA_W-1:0] scratch_rdata;
	logic ext_start;
	logic ext_done;
	logic [`DATA_W-1:0] port_rdata; // captured at ack

	access_tracker u_tracker (
		.modified_clock_sram (modified_clock_sram),
		.rst                 (rst),
		.sys_req             (sys_req),
		.sample              (sample),
		.access              (access)
	);

	scratch_ram u_scratch (
		.modified_clock_sram (modified_clock_sram),
		.we                  (scratch_we),
		.addr                (scratch_addr),
		.wdata               (scratch_wdata),
		.rdata               (scratch_rdata)
	);

	// system bus is held under pause, so it doubles as the command
	ext_mem_port u_ext_port (
		.modified_clock_sram (modified_clock_sram),
		.rst                 (rst),
		.start               (ext_start),
		.cmd                 (sys_req),
		.done                (ext_done),
		.rdata               (port_rdata),
		.ext_req             (ext_req),
		.ext_cmd             (ext_cmd),
		.ext_ack             (ext_ack),
		.ext_rdata           (ext_rdata)
	);

	access_sequencer u_seq (
		.modified_clock_sram (modified_clock_sram),
		.rst                 (rst),
		.slot                (slot),
		.ext_ready           (ext_ready),
		.sys_req             (sys_req),
		.access              (access),
		.sample              (sample),
		.scratch_we          (scratch_we),
		.scratch_addr        (scratch_addr),
		.scratch_wdata       (scratch_wdata),
		.scratch_rdata       (scratch_rdata),
		.ext_start           (ext_start),
		.ext_done            (ext_done),
		.ext_rdata           (port_rdata),
		.pause               (pause),
		.data_read           (data_read)
	);

endmodule

// ==== src/mem_manager_pkg.sv ====
`include "mem_manager_defs.svh"

package mem_manager_pkg;

	// --------------------------------------------------
	// one word request, system bus or external command
	// --------------------------------------------------
	typedef struct packed {
		logic wren;                    // 1 = write
		logic [`ADDR_W-1:0] addr;      // word address
		logic [`DATA_W-1:0] wdata;     // write data, ignored on reads
	} mem_word_req_t;

	// where a decoded address lands
	typedef enum logic [0:0] {
		REGION_SCRATCH = 1'b0,         // on-chip scratch RAM
		REGION_EXT     = 1'b1          // external memory
	} region_t;

	// --------------------------------------------------
	// decoded form of the sampled request
	// --------------------------------------------------
	typedef struct packed {
		logic hit;                     // same as last request, nothing to do
		region_t region;
		logic [`SCRATCH_AW-1:0] offset; // word offset inside the window
	} access_t;

endpackage

// ==== src/scratch_ram.sv ====
`timescale 1ns/1ps
`include "mem_manager_defs.svh"

// single-port scratch RAM, read-first, registered output
module scratch_ram (
	input  logic modified_clock_sram,
	input  logic we,
	input  logic [`SCRATCH_AW-1:0] addr,
	input  logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata
);

	// --------------------------------------------------
	// storage, block RAM shaped
	// --------------------------------------------------
	logic [`DATA_W-1:0] mem [`SCRATCH_WORDS];

	always_ff @(posedge modified_clock_sram) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // one clock after addr, old word on a write
	end

endmodule
